//--- Bender.yml
package:
  name: cce

sources:
  - src/cce_pkg.sv
  - src/cce_cfg.sv
  - src/cce_pc.sv
  - src/cce_exec.sv
  - src/cce_uncached.sv
  - src/cce_top.sv
  - target: test
    files:
      - testbench/cce_props.sv
      - testbench/tb_cce.sv

//--- src/cce_cfg.sv
// Configuration decoder: instruction RAM write strobes and the mode register
`timescale 1ns/1ps
`default_nettype none

module cce_cfg
  import cce_pkg::*;
  (input  logic         clk_i
   , input  logic       arst_n_i

   , input  logic       cfg_w_v_i
   , input  cfg_addr_t  cfg_addr_i
   , input  cfg_data_t  cfg_data_i

   , output logic       ram_w_v_o
   , output inst_addr_t ram_w_addr_o
   , output inst_t      ram_w_data_o

   , output cce_mode_e  mode_o
  );

  cce_mode_e mode_q;
  logic      mode_w_v;

  // Low addresses map straight onto instruction RAM entries
  assign ram_w_v_o    = cfg_w_v_i && (cfg_addr_i < cfg_addr_t'(INST_RAM_ELS));
  assign ram_w_addr_o = cfg_addr_i[INST_ADDR_WIDTH-1:0];
  assign ram_w_data_o = cfg_data_i;

  assign mode_w_v = cfg_w_v_i && (cfg_addr_i == CFG_MODE_ADDR);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mode_q <= e_mode_uncached;
    end else if (mode_w_v) begin
      mode_q <= cce_mode_e'(cfg_data_i[0]);
    end
  end

  assign mode_o = mode_q;

endmodule

`default_nettype wire

//--- src/cce_exec.sv
// Instruction decode, general register file, ALU and queue strobes for normal mode
`timescale 1ns/1ps
`default_nettype none

module cce_exec
  import cce_pkg::*;
  (input  logic         clk_i
   , input  logic       arst_n_i

   , input  inst_t      inst_i
   , input  logic       inst_v_i

   , output logic       stall_o
   , output logic       branch_v_o
   , output inst_addr_t branch_target_o

   // LCE request
   , input  paddr_t     lce_req_addr_i
   , input  lce_id_t    lce_req_lce_i
   , input  logic       lce_req_v_i
   , output logic       lce_req_yumi_o

   // LCE command
   , output lce_id_t    lce_cmd_lce_o
   , output paddr_t     lce_cmd_addr_o
   , output word_t      lce_cmd_data_o
   , output logic       lce_cmd_v_o
   , input  logic       lce_cmd_ready_i

   // Memory command
   , output paddr_t     mem_cmd_addr_o
   , output logic       mem_cmd_v_o
   , input  logic       mem_cmd_ready_i

   // Memory response
   , input  word_t      mem_resp_data_i
   , input  logic       mem_resp_v_i
   , output logic       mem_resp_yumi_o
  );

  cce_op_e                op;
  gpr_sel_t               rd;
  gpr_sel_t               ra;
  gpr_sel_t               rb;
  logic [IMM_WIDTH-1:0]   imm;

  word_t   gpr_q [NUM_GPR];
  lce_id_t lce_id_q;

  word_t   opd_a;
  word_t   opd_b;
  word_t   alu_sum;
  word_t   alu_diff;
  logic    alu_eq;

  logic    rd_w_v;
  word_t   rd_data;

  // Field extraction
  assign op  = cce_op_e'(inst_i[INST_OP_LSB +: $bits(cce_op_e)]);
  assign rd  = inst_i[INST_RD_LSB +: GPR_SEL_WIDTH];
  assign ra  = inst_i[INST_RA_LSB +: GPR_SEL_WIDTH];
  assign rb  = inst_i[INST_RB_LSB +: GPR_SEL_WIDTH];
  assign imm = inst_i[IMM_WIDTH-1:0];

  // addi shares the adder through operand b
  assign opd_a    = gpr_q[ra];
  assign opd_b    = (op == e_op_addi) ? word_t'(imm) : gpr_q[rb];
  assign alu_sum  = opd_a + opd_b;
  assign alu_diff = opd_a - opd_b;
  assign alu_eq   = (opd_a == opd_b);

  assign branch_target_o = imm[INST_ADDR_WIDTH-1:0];

  always_comb begin
    rd_w_v          = 1'b0;
    rd_data         = alu_sum;
    stall_o         = 1'b0;
    branch_v_o      = 1'b0;
    lce_req_yumi_o  = 1'b0;
    mem_resp_yumi_o = 1'b0;
    mem_cmd_v_o     = 1'b0;
    lce_cmd_v_o     = 1'b0;
    if (inst_v_i) begin
      case (op)
        e_op_add, e_op_addi: begin
          rd_w_v = 1'b1;
        end
        e_op_sub: begin
          rd_w_v  = 1'b1;
          rd_data = alu_diff;
        end
        e_op_beq: branch_v_o = alu_eq;
        e_op_bi:  branch_v_o = 1'b1;
        // Pops complete in the cycle their input is valid
        e_op_pop_req: begin
          lce_req_yumi_o = lce_req_v_i;
          stall_o        = ~lce_req_v_i;
          rd_w_v         = lce_req_v_i;
          rd_data        = word_t'(lce_req_addr_i);
        end
        e_op_pop_mem: begin
          mem_resp_yumi_o = mem_resp_v_i;
          stall_o         = ~mem_resp_v_i;
          rd_w_v          = mem_resp_v_i;
          rd_data         = mem_resp_data_i;
        end
        // Sends hold valid until the queue takes them
        e_op_send_mem: begin
          mem_cmd_v_o = 1'b1;
          stall_o     = ~mem_cmd_ready_i;
        end
        e_op_send_lce: begin
          lce_cmd_v_o = 1'b1;
          stall_o     = ~lce_cmd_ready_i;
        end
        default: begin
        end
      endcase
    end
  end

  assign mem_cmd_addr_o = paddr_t'(opd_a);
  assign lce_cmd_data_o = opd_a;
  assign lce_cmd_addr_o = paddr_t'(opd_b);
  assign lce_cmd_lce_o  = lce_id_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < NUM_GPR; i++) begin
        gpr_q[i] <= '0;
      end
      lce_id_q <= '0;
    end else begin
      if (rd_w_v) begin
        gpr_q[rd] <= rd_data;
      end
      // Requester is remembered for the reply
      if (lce_req_yumi_o) begin
        lce_id_q <= lce_req_lce_i;
      end
    end
  end

endmodule

`default_nettype wire

//--- src/cce_pc.sv
// Instruction RAM and program counter with stall and branch control
`timescale 1ns/1ps
`default_nettype none

module cce_pc
  import cce_pkg::*;
  (input  logic         clk_i
   , input  logic       arst_n_i

   , input  cce_mode_e  mode_i

   // Instruction RAM write port from configuration
   , input  logic       ram_w_v_i
   , input  inst_addr_t ram_w_addr_i
   , input  inst_t      ram_w_data_i

   // Flow control from execute
   , input  logic       stall_i
   , input  logic       branch_v_i
   , input  inst_addr_t branch_target_i

   , output inst_t      inst_o
   , output logic       inst_v_o
  );

  inst_t      inst_ram [INST_RAM_ELS];
  inst_addr_t pc_q;
  inst_addr_t pc_n;

  always_ff @(posedge clk_i) begin
    if (ram_w_v_i) begin
      inst_ram[ram_w_addr_i] <= ram_w_data_i;
    end
  end

  // Held at zero in uncached mode so normal mode always starts at the top
  always_comb begin
    if (mode_i == e_mode_uncached) begin
      pc_n = '0;
    end else if (stall_i) begin
      pc_n = pc_q;
    end else if (branch_v_i) begin
      pc_n = branch_target_i;
    end else begin
      pc_n = pc_q + inst_addr_t'(1);
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pc_q <= '0;
    end else begin
      pc_q <= pc_n;
    end
  end

  // Asynchronous read
  assign inst_o   = inst_ram[pc_q];
  assign inst_v_o = (mode_i == e_mode_normal);

endmodule

`default_nettype wire

//--- src/cce_pkg.sv
// Widths, data types, opcode and mode encodings, and configuration address map of the CCE
`default_nettype none

package cce_pkg;

  localparam int PADDR_WIDTH    = 16;
  localparam int WORD_WIDTH     = 16;
  localparam int LCE_ID_WIDTH   = 2;
  localparam int NUM_GPR        = 4;
  localparam int GPR_SEL_WIDTH  = $clog2(NUM_GPR);
  localparam int INST_RAM_ELS   = 32;
  localparam int INST_ADDR_WIDTH = $clog2(INST_RAM_ELS);
  localparam int INST_WIDTH     = 20;
  localparam int IMM_WIDTH      = 10;
  localparam int CFG_ADDR_WIDTH = 6;
  localparam int CFG_DATA_WIDTH = 20;

  // Instruction field positions, opcode on top and imm at the bottom
  localparam int INST_OP_LSB = 16;
  localparam int INST_RD_LSB = 14;
  localparam int INST_RA_LSB = 12;
  localparam int INST_RB_LSB = 10;

  typedef logic [PADDR_WIDTH-1:0]     paddr_t;
  typedef logic [WORD_WIDTH-1:0]      word_t;
  typedef logic [LCE_ID_WIDTH-1:0]    lce_id_t;
  typedef logic [GPR_SEL_WIDTH-1:0]   gpr_sel_t;
  typedef logic [INST_ADDR_WIDTH-1:0] inst_addr_t;
  typedef logic [INST_WIDTH-1:0]      inst_t;
  typedef logic [CFG_ADDR_WIDTH-1:0]  cfg_addr_t;
  typedef logic [CFG_DATA_WIDTH-1:0]  cfg_data_t;

  // Mode register lives just above the instruction RAM entries
  localparam cfg_addr_t CFG_MODE_ADDR = cfg_addr_t'(32);

  typedef enum logic {
    e_mode_uncached = 1'b0,
    e_mode_normal   = 1'b1
  } cce_mode_e;

  typedef enum logic [3:0] {
    e_op_nop      = 4'h0,
    e_op_add      = 4'h1,
    e_op_sub      = 4'h2,
    e_op_addi     = 4'h3,
    e_op_beq      = 4'h4,
    e_op_bi       = 4'h5,
    e_op_pop_req  = 4'h6,
    e_op_pop_mem  = 4'h7,
    e_op_send_mem = 4'h8,
    e_op_send_lce = 4'h9
  } cce_op_e;

endpackage

`default_nettype wire

//--- src/cce_top.sv
// CCE top level: configuration, PC, execute and uncached units with queue merging
`timescale 1ns/1ps
`default_nettype none

module cce_top
  import cce_pkg::*;
  (input  logic       clk_i
   , input  logic     arst_n_i

   , input  logic      cfg_w_v_i
   , input  cfg_addr_t cfg_addr_i
   , input  cfg_data_t cfg_data_i

   , input  paddr_t   lce_req_addr_i
   , input  lce_id_t  lce_req_lce_i
   , input  logic     lce_req_v_i
   , output logic     lce_req_yumi_o

   , input  word_t    mem_resp_data_i
   , input  logic     mem_resp_v_i
   , output logic     mem_resp_yumi_o

   , output paddr_t   mem_cmd_addr_o
   , output logic     mem_cmd_v_o
   , input  logic     mem_cmd_ready_i

   , output lce_id_t  lce_cmd_lce_o
   , output paddr_t   lce_cmd_addr_o
   , output word_t    lce_cmd_data_o
   , output logic     lce_cmd_v_o
   , input  logic     lce_cmd_ready_i
  );

  cce_mode_e  mode;
  logic       ram_w_v;
  inst_addr_t ram_w_addr;
  inst_t      ram_w_data;
  inst_t      inst;
  logic       inst_v;
  logic       stall;
  logic       branch_v;
  inst_addr_t branch_target;

  // Message unit outputs
  logic    lce_req_yumi_exec, lce_req_yumi_uc;
  logic    mem_resp_yumi_exec, mem_resp_yumi_uc;
  paddr_t  mem_cmd_addr_exec, mem_cmd_addr_uc;
  logic    mem_cmd_v_exec, mem_cmd_v_uc;
  lce_id_t lce_cmd_lce_exec, lce_cmd_lce_uc;
  paddr_t  lce_cmd_addr_exec, lce_cmd_addr_uc;
  word_t   lce_cmd_data_exec, lce_cmd_data_uc;
  logic    lce_cmd_v_exec, lce_cmd_v_uc;

  cce_cfg cfg
    (.clk_i(clk_i), .arst_n_i(arst_n_i)
     ,.cfg_w_v_i(cfg_w_v_i), .cfg_addr_i(cfg_addr_i), .cfg_data_i(cfg_data_i)
     ,.ram_w_v_o(ram_w_v), .ram_w_addr_o(ram_w_addr), .ram_w_data_o(ram_w_data)
     ,.mode_o(mode)
    );

  cce_pc pc
    (.clk_i(clk_i), .arst_n_i(arst_n_i), .mode_i(mode)
     ,.ram_w_v_i(ram_w_v), .ram_w_addr_i(ram_w_addr), .ram_w_data_i(ram_w_data)
     ,.stall_i(stall), .branch_v_i(branch_v), .branch_target_i(branch_target)
     ,.inst_o(inst), .inst_v_o(inst_v)
    );

  cce_exec exec
    (.clk_i(clk_i), .arst_n_i(arst_n_i), .inst_i(inst), .inst_v_i(inst_v)
     ,.stall_o(stall), .branch_v_o(branch_v), .branch_target_o(branch_target)
     ,.lce_req_addr_i(lce_req_addr_i), .lce_req_lce_i(lce_req_lce_i)
     ,.lce_req_v_i(lce_req_v_i), .lce_req_yumi_o(lce_req_yumi_exec)
     ,.lce_cmd_lce_o(lce_cmd_lce_exec), .lce_cmd_addr_o(lce_cmd_addr_exec)
     ,.lce_cmd_data_o(lce_cmd_data_exec), .lce_cmd_v_o(lce_cmd_v_exec)
     ,.lce_cmd_ready_i(lce_cmd_ready_i)
     ,.mem_cmd_addr_o(mem_cmd_addr_exec), .mem_cmd_v_o(mem_cmd_v_exec)
     ,.mem_cmd_ready_i(mem_cmd_ready_i)
     ,.mem_resp_data_i(mem_resp_data_i), .mem_resp_v_i(mem_resp_v_i)
     ,.mem_resp_yumi_o(mem_resp_yumi_exec)
    );

  cce_uncached uncached
    (.clk_i(clk_i), .arst_n_i(arst_n_i), .mode_i(mode)
     ,.lce_req_addr_i(lce_req_addr_i), .lce_req_lce_i(lce_req_lce_i)
     ,.lce_req_v_i(lce_req_v_i), .lce_req_yumi_o(lce_req_yumi_uc)
     ,.lce_cmd_lce_o(lce_cmd_lce_uc), .lce_cmd_addr_o(lce_cmd_addr_uc)
     ,.lce_cmd_data_o(lce_cmd_data_uc), .lce_cmd_v_o(lce_cmd_v_uc)
     ,.lce_cmd_ready_i(lce_cmd_ready_i)
     ,.mem_cmd_addr_o(mem_cmd_addr_uc), .mem_cmd_v_o(mem_cmd_v_uc)
     ,.mem_cmd_ready_i(mem_cmd_ready_i)
     ,.mem_resp_data_i(mem_resp_data_i), .mem_resp_v_i(mem_resp_v_i)
     ,.mem_resp_yumi_o(mem_resp_yumi_uc)
    );

  // Only one unit is ever active, so strobes simply OR together
  assign lce_req_yumi_o  = lce_req_yumi_exec | lce_req_yumi_uc;
  assign mem_resp_yumi_o = mem_resp_yumi_exec | mem_resp_yumi_uc;
  assign mem_cmd_v_o     = mem_cmd_v_exec | mem_cmd_v_uc;
  assign lce_cmd_v_o     = lce_cmd_v_exec | lce_cmd_v_uc;

  assign mem_cmd_addr_o = mem_cmd_v_exec ? mem_cmd_addr_exec : mem_cmd_addr_uc;
  assign lce_cmd_lce_o  = lce_cmd_v_exec ? lce_cmd_lce_exec  : lce_cmd_lce_uc;
  assign lce_cmd_addr_o = lce_cmd_v_exec ? lce_cmd_addr_exec : lce_cmd_addr_uc;
  assign lce_cmd_data_o = lce_cmd_v_exec ? lce_cmd_data_exec : lce_cmd_data_uc;

endmodule

`default_nettype wire

//--- src/cce_uncached.sv
// Uncached access FSM: LCE read to memory command, memory reply back to the LCE
`timescale 1ns/1ps
`default_nettype none

module cce_uncached
  import cce_pkg::*;
  (input  logic        clk_i
   , input  logic      arst_n_i

   , input  cce_mode_e mode_i

   , input  paddr_t    lce_req_addr_i
   , input  lce_id_t   lce_req_lce_i
   , input  logic      lce_req_v_i
   , output logic      lce_req_yumi_o

   , output lce_id_t   lce_cmd_lce_o
   , output paddr_t    lce_cmd_addr_o
   , output word_t     lce_cmd_data_o
   , output logic      lce_cmd_v_o
   , input  logic      lce_cmd_ready_i

   , output paddr_t    mem_cmd_addr_o
   , output logic      mem_cmd_v_o
   , input  logic      mem_cmd_ready_i

   , input  word_t     mem_resp_data_i
   , input  logic      mem_resp_v_i
   , output logic      mem_resp_yumi_o
  );

  typedef enum logic [1:0] {
    e_uc_ready,
    e_uc_send_mem_cmd,
    e_uc_wait_mem_resp,
    e_uc_send_lce_cmd
  } uc_state_e;

  uc_state_e state_q;
  uc_state_e state_n;
  logic      req_take;

  paddr_t    addr_q;
  lce_id_t   lce_q;
  word_t     data_q;

  assign req_take = (state_q == e_uc_ready) && (mode_i == e_mode_uncached) && lce_req_v_i;

  always_comb begin
    state_n         = state_q;
    mem_cmd_v_o     = 1'b0;
    mem_resp_yumi_o = 1'b0;
    lce_cmd_v_o     = 1'b0;
    case (state_q)
      e_uc_ready: begin
        if (req_take) state_n = e_uc_send_mem_cmd;
      end
      e_uc_send_mem_cmd: begin
        mem_cmd_v_o = 1'b1;
        if (mem_cmd_ready_i) state_n = e_uc_wait_mem_resp;
      end
      e_uc_wait_mem_resp: begin
        mem_resp_yumi_o = mem_resp_v_i;
        if (mem_resp_v_i) state_n = e_uc_send_lce_cmd;
      end
      e_uc_send_lce_cmd: begin
        lce_cmd_v_o = 1'b1;
        if (lce_cmd_ready_i) state_n = e_uc_ready;
      end
      default: state_n = e_uc_ready;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= e_uc_ready;
    end else begin
      state_q <= state_n;
    end
  end

  // Captured request and reply stay put while the queues push back
  always_ff @(posedge clk_i) begin
    if (req_take) begin
      addr_q <= lce_req_addr_i;
      lce_q  <= lce_req_lce_i;
    end
    if (mem_resp_yumi_o) begin
      data_q <= mem_resp_data_i;
    end
  end

  assign lce_req_yumi_o = req_take;
  assign mem_cmd_addr_o = addr_q;
  assign lce_cmd_lce_o  = lce_q;
  assign lce_cmd_addr_o = addr_q;
  assign lce_cmd_data_o = data_q;

endmodule

`default_nettype wire

//--- tb.f
src/cce_pkg.sv
src/cce_cfg.sv
src/cce_pc.sv
src/cce_exec.sv
src/cce_uncached.sv
src/cce_top.sv
testbench/cce_props.sv
testbench/tb_cce.sv

//--- testbench/cce_props.sv
// Queue protocol assertions bound to cce_top
`timescale 1ns/1ps
`default_nettype none

module cce_props
  import cce_pkg::*;
  (input  logic    clk_i
   , input  logic  arst_n_i
   , input  logic  lce_req_v_i
   , input  logic  lce_req_yumi_o
   , input  logic  mem_resp_v_i
   , input  logic  mem_resp_yumi_o
   , input  paddr_t  mem_cmd_addr_o
   , input  logic    mem_cmd_v_o
   , input  logic    mem_cmd_ready_i
   , input  lce_id_t lce_cmd_lce_o
   , input  paddr_t  lce_cmd_addr_o
   , input  word_t   lce_cmd_data_o
   , input  logic    lce_cmd_v_o
   , input  logic    lce_cmd_ready_i
  );

  int fail_count = 0;

  // Command queues hold valid and payload under back-pressure
  mem_cmd_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mem_cmd_v_o && !mem_cmd_ready_i |=> mem_cmd_v_o && $stable(mem_cmd_addr_o))
    else begin
      $error("mem_cmd valid or address changed while stalled");
      fail_count++;
    end

  lce_cmd_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    lce_cmd_v_o && !lce_cmd_ready_i |=> lce_cmd_v_o && $stable(lce_cmd_lce_o)
      && $stable(lce_cmd_addr_o) && $stable(lce_cmd_data_o))
    else begin
      $error("lce_cmd valid or payload changed while stalled");
      fail_count++;
    end

  yumi_needs_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (lce_req_yumi_o |-> lce_req_v_i) and (mem_resp_yumi_o |-> mem_resp_v_i))
    else begin
      $error("yumi raised without a valid input");
      fail_count++;
    end

  quiet_after_reset: assert property (@(posedge clk_i)
    $rose(arst_n_i) |-> !(lce_req_yumi_o || mem_resp_yumi_o || mem_cmd_v_o || lce_cmd_v_o))
    else begin
      $error("valid or yumi high in the first cycle after reset");
      fail_count++;
    end

endmodule

bind cce_top cce_props props (.*);

`default_nettype wire

//--- testbench/tb_cce.sv
// Directed tests, LCE and memory models, LFSR and watchdog for cce_top
`timescale 1ns/1ps
`default_nettype none

module tb_cce
  import cce_pkg::*;
  ();

  localparam logic [31:0] LFSR_SEED = 32'h2286_6360;
  // Worst case per read with full back-pressure on both commands
  localparam int TXN_CYCLES      = 40;
  localparam int NUM_TXNS        = 8 + 6 + 4 + 3;
  localparam int SETUP_CYCLES    = 100;
  localparam int WATCHDOG_CYCLES = NUM_TXNS * TXN_CYCLES + SETUP_CYCLES;

  logic      clk_i = 1'b0;
  logic      arst_n_i;
  logic      cfg_w_v_i;
  cfg_addr_t cfg_addr_i;
  cfg_data_t cfg_data_i;
  paddr_t    lce_req_addr_i;
  lce_id_t   lce_req_lce_i;
  logic      lce_req_v_i;
  logic      lce_req_yumi_o;
  word_t     mem_resp_data_i;
  logic      mem_resp_v_i;
  logic      mem_resp_yumi_o;
  paddr_t    mem_cmd_addr_o;
  logic      mem_cmd_v_o;
  logic      mem_cmd_ready_i;
  lce_id_t   lce_cmd_lce_o;
  paddr_t    lce_cmd_addr_o;
  word_t     lce_cmd_data_o;
  logic      lce_cmd_v_o;
  logic      lce_cmd_ready_i;

  logic [31:0] lfsr_q;
  string       cur_test;
  int          test_errors;
  int          total_errors;
  int          prop_errors;
  int          tests_run;
  int          tests_failed;

  cce_top UUT (.*);

  always #10 clk_i = ~clk_i;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
  endtask

  // Opcode on top followed by rd, ra, rb and imm
  function automatic inst_t encode(input cce_op_e op, input gpr_sel_t rd, input gpr_sel_t ra,
                                   input gpr_sel_t rb, input logic [9:0] imm);
    return {op, rd, ra, rb, imm};
  endfunction

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (expected == actual) else begin
      $display("FAILED %s %s: expected %h, got %h", cur_test, what, expected, actual);
      test_errors++;
    end
  endtask

  task automatic check_true(input string what, input logic cond);
    assert (cond === 1'b1) else begin
      $display("ERROR in %s: %s", cur_test, what);
      test_errors++;
    end
  endtask

  task automatic start_test(input string name);
    cur_test    = name;
    test_errors = 0;
  endtask

  task automatic finish_test();
    tests_run++;
    total_errors += test_errors;
    if (test_errors != 0) begin
      tests_failed++;
      $display("test %s: %0d check(s) failed", cur_test, test_errors);
    end else begin
      $display("test %s: ok", cur_test);
    end
  endtask

  task automatic cfg_write(input cfg_addr_t addr, input cfg_data_t data);
    @(negedge clk_i);
    cfg_w_v_i  = 1'b1;
    cfg_addr_i = addr;
    cfg_data_i = data;
    @(negedge clk_i);
    cfg_w_v_i = 1'b0;
  endtask

  task automatic load_program(input inst_t prog [$]);
    foreach (prog[i]) begin
      cfg_write(cfg_addr_t'(i), prog[i]);
    end
  endtask

  // One read end to end with outputs sampled 5 ns after the falling edge
  task automatic run_read(input paddr_t addr, input lce_id_t lce, input word_t data,
                          output paddr_t cmd_addr, output lce_id_t rsp_lce,
                          output paddr_t rsp_addr, output word_t rsp_data);
    logic [31:0] delay;
    @(negedge clk_i);
    lce_req_v_i    = 1'b1;
    lce_req_addr_i = addr;
    lce_req_lce_i  = lce;
    #5;
    while (!lce_req_yumi_o) begin
      @(negedge clk_i);
      #5;
    end
    @(negedge clk_i);
    lce_req_v_i = 1'b0;
    #5;
    while (!mem_cmd_v_o) begin
      @(negedge clk_i);
      #5;
    end
    rand_bits(2, delay);
    repeat (delay) @(negedge clk_i);
    @(negedge clk_i);
    mem_cmd_ready_i = 1'b1;
    #5;
    check_true("mem_cmd_v_o dropped before ready", mem_cmd_v_o);
    cmd_addr = mem_cmd_addr_o;
    @(negedge clk_i);
    mem_cmd_ready_i = 1'b0;
    rand_bits(2, delay);
    repeat (delay) @(negedge clk_i);
    @(negedge clk_i);
    mem_resp_v_i    = 1'b1;
    mem_resp_data_i = data;
    #5;
    while (!mem_resp_yumi_o) begin
      @(negedge clk_i);
      #5;
    end
    @(negedge clk_i);
    mem_resp_v_i = 1'b0;
    #5;
    while (!lce_cmd_v_o) begin
      @(negedge clk_i);
      #5;
    end
    rand_bits(2, delay);
    repeat (delay) @(negedge clk_i);
    @(negedge clk_i);
    lce_cmd_ready_i = 1'b1;
    #5;
    check_true("lce_cmd_v_o dropped before ready", lce_cmd_v_o);
    rsp_lce  = lce_cmd_lce_o;
    rsp_addr = lce_cmd_addr_o;
    rsp_data = lce_cmd_data_o;
    @(negedge clk_i);
    lce_cmd_ready_i = 1'b0;
  endtask

  task automatic uncached_reads(input int count);
    logic [31:0] addr;
    logic [31:0] lce;
    logic [31:0] data;
    paddr_t      cmd_addr;
    lce_id_t     rsp_lce;
    paddr_t      rsp_addr;
    word_t       rsp_data;
    for (int i = 0; i < count; i++) begin
      rand_bits(16, addr);
      rand_bits(2, lce);
      rand_bits(16, data);
      run_read(paddr_t'(addr), lce_id_t'(lce), word_t'(data),
               cmd_addr, rsp_lce, rsp_addr, rsp_data);
      check_value("mem_cmd_addr", addr[15:0], cmd_addr);
      check_value("lce_cmd_lce", lce[1:0], rsp_lce);
      check_value("lce_cmd_addr", addr[15:0], rsp_addr);
      check_value("lce_cmd_data", data[15:0], rsp_data);
    end
  endtask

  task automatic test_idle();
    start_test("idle_after_reset");
    repeat (4) begin
      @(negedge clk_i);
      #5;
      check_true("a valid or yumi is high with no request",
                 !(lce_req_yumi_o || mem_resp_yumi_o || mem_cmd_v_o || lce_cmd_v_o));
    end
    finish_test();
  endtask

  task automatic test_uncached();
    start_test("uncached_reads");
    uncached_reads(8);
    finish_test();
  endtask

  task automatic test_microcode();
    logic [31:0] addr;
    logic [31:0] lce;
    logic [31:0] data;
    paddr_t      cmd_addr;
    lce_id_t     rsp_lce;
    paddr_t      rsp_addr;
    word_t       rsp_data;
    start_test("microcode_normal");
    load_program('{encode(e_op_pop_req, 0, 0, 0, 0), encode(e_op_addi, 1, 0, 0, 16),
                   encode(e_op_send_mem, 0, 1, 0, 0), encode(e_op_pop_mem, 2, 0, 0, 0),
                   encode(e_op_add, 3, 2, 2, 0), encode(e_op_send_lce, 0, 3, 0, 0),
                   encode(e_op_bi, 0, 0, 0, 0)});
    cfg_write(CFG_MODE_ADDR, cfg_data_t'(e_mode_normal));
    for (int i = 0; i < 6; i++) begin
      rand_bits(16, addr);
      rand_bits(2, lce);
      rand_bits(16, data);
      run_read(paddr_t'(addr), lce_id_t'(lce), word_t'(data),
               cmd_addr, rsp_lce, rsp_addr, rsp_data);
      check_value("mem_cmd_addr", paddr_t'(addr[15:0] + 16'd16), cmd_addr);
      check_value("lce_cmd_data", word_t'(data[15:0] + data[15:0]), rsp_data);
      check_value("lce_cmd_addr", addr[15:0], rsp_addr);
      check_value("lce_cmd_lce", lce[1:0], rsp_lce);
    end
    finish_test();
  endtask

  task automatic test_branch();
    logic [31:0] addr;
    logic [31:0] lce;
    logic [31:0] data;
    word_t       expected;
    paddr_t      cmd_addr;
    lce_id_t     rsp_lce;
    paddr_t      rsp_addr;
    word_t       rsp_data;
    start_test("branch_beq");
    // Fresh reset so r3 reads zero
    @(negedge clk_i);
    arst_n_i = 1'b0;
    repeat (2) @(negedge clk_i);
    arst_n_i = 1'b1;
    load_program('{encode(e_op_pop_req, 0, 0, 0, 0), encode(e_op_addi, 1, 0, 0, 16),
                   encode(e_op_send_mem, 0, 1, 0, 0), encode(e_op_pop_mem, 2, 0, 0, 0),
                   encode(e_op_beq, 0, 2, 3, 7), encode(e_op_send_lce, 0, 2, 0, 0),
                   encode(e_op_bi, 0, 0, 0, 0), encode(e_op_sub, 1, 0, 2, 0),
                   encode(e_op_send_lce, 0, 1, 0, 0), encode(e_op_bi, 0, 0, 0, 0)});
    cfg_write(CFG_MODE_ADDR, cfg_data_t'(e_mode_normal));
    for (int i = 0; i < 4; i++) begin
      rand_bits(16, addr);
      rand_bits(2, lce);
      rand_bits(16, data);
      if (i % 2 == 0) data = '0;
      else if (data[15:0] == '0) data = 32'd1;
      // Zero data takes the sub path and anything else falls through
      expected = (data[15:0] == '0) ? word_t'(addr[15:0] - data[15:0]) : word_t'(data);
      run_read(paddr_t'(addr), lce_id_t'(lce), word_t'(data),
               cmd_addr, rsp_lce, rsp_addr, rsp_data);
      check_value("mem_cmd_addr", paddr_t'(addr[15:0] + 16'd16), cmd_addr);
      check_value("lce_cmd_data", expected, rsp_data);
      check_value("lce_cmd_addr", addr[15:0], rsp_addr);
      check_value("lce_cmd_lce", lce[1:0], rsp_lce);
    end
    finish_test();
  endtask

  task automatic test_mode_return();
    start_test("mode_return");
    cfg_write(CFG_MODE_ADDR, cfg_data_t'(e_mode_uncached));
    uncached_reads(3);
    finish_test();
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, a handshake never completed",
             WATCHDOG_CYCLES);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    arst_n_i        = 1'b0;
    cfg_w_v_i       = 1'b0;
    cfg_addr_i      = '0;
    cfg_data_i      = '0;
    lce_req_addr_i  = '0;
    lce_req_lce_i   = '0;
    lce_req_v_i     = 1'b0;
    mem_resp_data_i = '0;
    mem_resp_v_i    = 1'b0;
    mem_cmd_ready_i = 1'b0;
    lce_cmd_ready_i = 1'b0;
    lfsr_q          = LFSR_SEED;
    total_errors    = 0;
    prop_errors     = 0;
    tests_run       = 0;
    tests_failed    = 0;
    repeat (2) @(negedge clk_i);
    arst_n_i = 1'b1;
    test_idle();
    test_uncached();
    test_microcode();
    test_branch();
    test_mode_return();
    @(negedge clk_i);
    // Protocol assertion failures from the bound checker count as well
    prop_errors = UUT.props.fail_count;
    $display("%0d tests run, %0d failed, %0d checks failed, %0d assertion failures",
             tests_run, tests_failed, total_errors, prop_errors);
    if (total_errors == 0 && prop_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
